//--- sim/rr_input_vectors.txt
// First data line: buffer size in words for the overflow test
// Then one unit per line: bitmap ch0 ch1 ch2 ch3 (hex), expected length in bits (decimal)
4
f a5 1234 5a deadbeef 68
1 3c 0000 00 00000000 12
2 00 beef 00 00000000 20
0 00 0000 00 00000000 4
8 00 0000 00 cafef00d 36
3 11 2233 00 00000000 28
4 00 0000 7e 00000000 12
5 81 0000 42 00000000 20
6 00 9abc ef 00000000 28
7 01 0203 04 00000000 36
9 ff 0000 00 01234567 44
a 00 55aa 00 89abcdef 52
b 77 6655 00 44332211 60
c 00 0000 c3 0f0f0f0f 44
d 12 0000 34 56789abc 52
e 00 fedc ba 98765432 60
f 00 0000 00 00000000 68
f ff ffff ff ffffffff 68
1 80 0000 00 00000000 12
8 00 0000 00 80000001 36
0 00 0000 00 00000000 4
2 00 0001 00 00000000 20
7 ee 00dd cc 00000000 36
b 10 2030 00 40506070 60

//--- all.f
src/rr_pkg.sv
src/rr_trace_mem.sv
src/rr_record_packer.sv
src/rr_replay_unpacker.sv
src/rr_backend_csr.sv
src/rr_storage_backend.sv
sim/tb_rr_storage_backend.sv

//--- sim/tb_rr_storage_backend.sv
`timescale 1ns/1ps

module tb_rr_storage_backend;
  import rr_pkg::*;

  localparam int max_vec = 32;
  localparam int wait_limit = 400;
  localparam int quiet_window = 50;

  logic                     clk, rstn;
  logic                     record_valid, record_ready;
  logic [max_unit_bits-1:0] record_data;
  logic [unit_len_bits-1:0] record_len;
  logic                     replay_valid, replay_ready;
  logic [max_unit_bits-1:0] replay_data;
  logic [unit_len_bits-1:0] replay_len;
  logic                     reg_wr;
  logic [reg_addr_bits-1:0] reg_addr;
  logic [31:0]              reg_wdata, reg_rdata;
  logic                     irq_req, irq_ack;

  logic [max_unit_bits-1:0] vec_unit [max_vec];
  logic [unit_len_bits-1:0] vec_len [max_vec];
  logic [chan_cnt-1:0]      vec_bm [max_vec];
  int n_vec, small_buf, rec_total, errors, timeouts;
  int rec_q[$];

  rr_storage_backend rr_storage_backend_inst (
    .clk          (clk),
    .rstn         (rstn),
    .record_valid (record_valid),
    .record_ready (record_ready),
    .record_data  (record_data),
    .record_len   (record_len),
    .replay_valid (replay_valid),
    .replay_ready (replay_ready),
    .replay_data  (replay_data),
    .replay_len   (replay_len),
    .reg_wr       (reg_wr),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .irq_req      (irq_req),
    .irq_ack      (irq_ack)
  );

  always #2 clk = ~clk;

  // Reference packing puts the bitmap at the bottom and stacks the valid payloads above it
  function automatic logic [67:0] pack_unit(input logic [3:0] bm, input logic [7:0] c0,
                                            input logic [15:0] c1, input logic [7:0] c2,
                                            input logic [31:0] c3);
    logic [67:0] u;
    int pos;
    u = 68'(bm);
    pos = 4;
    if (bm[0]) begin
      u = u | (68'(c0) << pos);
      pos = pos + 8;
    end
    if (bm[1]) begin
      u = u | (68'(c1) << pos);
      pos = pos + 16;
    end
    if (bm[2]) begin
      u = u | (68'(c2) << pos);
      pos = pos + 8;
    end
    if (bm[3]) begin
      u = u | (68'(c3) << pos);
    end
    return u;
  endfunction

  task automatic report_mismatch(input string name, input logic [67:0] exp,
                                 input logic [67:0] act);
    errors++;
    $display("Fail %s expected %0h actual %0h", name, exp, act);
  endtask

  task automatic load_vectors();
    int fd, bm, c0, c1, c2, c3, len;
    bit have_size;
    string line;
    fd = $fopen("sim/rr_input_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("The vector file could not be opened");
      return;
    end
    have_size = 1'b0;
    n_vec = 0;
    while (!$feof(fd) && n_vec < max_vec) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "/") begin
        continue;
      end
      if (!have_size) begin
        void'($sscanf(line, "%d", small_buf));
        have_size = 1'b1;
      end else if ($sscanf(line, "%h %h %h %h %h %d", bm, c0, c1, c2, c3, len) == 6) begin
        vec_bm[n_vec] = 4'(bm);
        vec_unit[n_vec] = pack_unit(4'(bm), 8'(c0), 16'(c1), 8'(c2), 32'(c3));
        vec_len[n_vec] = 7'(len);
        n_vec++;
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_reset();
    rstn = 1'b0;
    record_valid = 1'b0;
    replay_ready = 1'b0;
    reg_wr = 1'b0;
    irq_ack = 1'b0;
    repeat (4) @(negedge clk);
    rstn = 1'b1;
  endtask

  task automatic write_reg(input logic [reg_addr_bits-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_wr = 1'b1;
    reg_addr = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input logic [reg_addr_bits-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    reg_addr = addr;
    #1;
    data = reg_rdata;
  endtask

  task automatic wait_irq(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!irq_req && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!irq_req) begin
      timeouts++;
      $display("Timeout: irq_req never rose during %s", name);
    end
  endtask

  // Holds the unit until it is taken, or until the buffer-full interrupt shows up
  task automatic send_unit(input int idx, output bit taken);
    int n;
    taken = 1'b0;
    n = 0;
    @(negedge clk);
    repeat ($urandom % 3) @(negedge clk);
    record_data = vec_unit[idx];
    record_len = vec_len[idx];
    record_valid = 1'b1;
    #1;
    while (!record_ready && !irq_req && n < wait_limit) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (record_ready) begin
      taken = 1'b1;
    end else if (!irq_req) begin
      timeouts++;
      $display("Timeout: unit %0d was never accepted", idx);
    end
    @(negedge clk);
    record_valid = 1'b0;
  endtask

  task automatic record_test();
    logic [31:0] rd;
    bit taken;
    rec_total = 0;
    for (int i = 0; i < n_vec; i++) begin
      if (unit_len(vec_bm[i]) != vec_len[i]) begin
        report_mismatch("unit_len", vec_len[i], unit_len(vec_bm[i]));
      end
      send_unit(i, taken);
      if (taken) begin
        rec_q.push_back(i);
        rec_total += vec_len[i];
      end else begin
        errors++;
        $display("Unit %0d was refused while recording", i);
      end
    end
    write_reg(reg_ctrl, 32'd1);
    wait_irq("record finish");
    read_reg(reg_record_bits, rd);
    if (rd != rec_total) begin
      report_mismatch("record_bits", rec_total, rd);
    end
    read_reg(reg_irq_status, rd);
    if (rd != 32'd1) begin
      report_mismatch("irq_status after record", 1, rd);
    end
    // A one-cycle acknowledge clears the request on the next edge
    @(negedge clk);
    irq_ack = 1'b1;
    @(negedge clk);
    irq_ack = 1'b0;
    #1;
    if (irq_req !== 1'b0) begin
      report_mismatch("irq_req after ack", 0, irq_req);
    end
    write_reg(reg_irq_status, 32'd0);
    read_reg(reg_irq_status, rd);
    if (rd != 32'd0) begin
      report_mismatch("irq_status clear", 0, rd);
    end
  endtask

  task automatic replay_test();
    logic [31:0] rd;
    int idx, n;
    write_reg(reg_replay_bits, rec_total);
    write_reg(reg_ctrl, 32'd2);
    while (rec_q.size() > 0) begin
      idx = rec_q.pop_front();
      n = 0;
      @(negedge clk);
      replay_ready = ($urandom % 3) != 0;
      #1;
      while (!(replay_valid && replay_ready) && n < wait_limit) begin
        @(negedge clk);
        replay_ready = ($urandom % 3) != 0;
        #1;
        n++;
      end
      if (!(replay_valid && replay_ready)) begin
        timeouts++;
        $display("Timeout: replay of unit %0d never arrived", idx);
        break;
      end
      if (replay_data !== vec_unit[idx]) begin
        report_mismatch($sformatf("replay_data unit %0d", idx), vec_unit[idx], replay_data);
      end
      if (replay_len !== vec_len[idx]) begin
        report_mismatch($sformatf("replay_len unit %0d", idx), vec_len[idx], replay_len);
      end
    end
    @(negedge clk);
    replay_ready = 1'b1;
    wait_irq("replay");
    read_reg(reg_irq_status, rd);
    if (rd != 32'd2) begin
      report_mismatch("irq_status after replay", 2, rd);
    end
    for (n = 0; n < quiet_window; n++) begin
      @(negedge clk);
      if (replay_valid) begin
        errors++;
        $display("replay_valid came back after the last unit");
        break;
      end
    end
    replay_ready = 1'b0;
  endtask

  task automatic overflow_test();
    logic [31:0] rd;
    int total, i, n, short_idx;
    bit taken;
    apply_reset();
    write_reg(reg_buf_size, small_buf);
    total = 0;
    i = 0;
    taken = 1'b1;
    while (taken && i < n_vec) begin
      send_unit(i, taken);
      if (taken) begin
        total += vec_len[i];
      end
      i++;
    end
    if (taken) begin
      errors++;
      $display("The small buffer never filled up");
      return;
    end
    wait_irq("buffer full");
    // Even the shortest unit must be kept out once the buffer is full
    short_idx = 0;
    for (n = 1; n < n_vec; n++) begin
      if (vec_len[n] < vec_len[short_idx]) begin
        short_idx = n;
      end
    end
    @(negedge clk);
    record_data = vec_unit[short_idx];
    record_len = vec_len[short_idx];
    record_valid = 1'b1;
    for (n = 0; n < 20; n++) begin
      #1;
      if (record_ready !== 1'b0) begin
        errors++;
        $display("record_ready rose again after the buffer was full");
        break;
      end
      @(negedge clk);
    end
    record_valid = 1'b0;
    read_reg(reg_irq_status, rd);
    if (rd != 32'd1) begin
      report_mismatch("irq_status buffer full", 1, rd);
    end
    read_reg(reg_record_bits, rd);
    if (rd != total) begin
      report_mismatch("record_bits buffer full", total, rd);
    end
    if (int'(rd) < 32 * small_buf - 67 || int'(rd) > 32 * small_buf) begin
      errors++;
      $display("Recorded bit count %0d does not fit a buffer of %0d words", rd, small_buf);
    end
  endtask

  initial begin
    void'($urandom(32'h7976bfb3));
    clk = 1'b0;
    rstn = 1'b0;
    record_valid = 1'b0;
    record_data = '0;
    record_len = '0;
    replay_ready = 1'b0;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    irq_ack = 1'b0;
    errors = 0;
    timeouts = 0;
    n_vec = 0;
    load_vectors();
    apply_reset();
    if (n_vec == 0) begin
      errors++;
      $display("No units were loaded from the vector file");
    end else begin
      record_test();
      replay_test();
      overflow_test();
    end
    $display("Errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- src/rr_storage_backend.sv
`timescale 1ns/1ps

module rr_storage_backend (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             record_valid,
  output logic                             record_ready,
  input  logic [rr_pkg::max_unit_bits-1:0] record_data,
  input  logic [rr_pkg::unit_len_bits-1:0] record_len,
  output logic                             replay_valid,
  input  logic                             replay_ready,
  output logic [rr_pkg::max_unit_bits-1:0] replay_data,
  output logic [rr_pkg::unit_len_bits-1:0] replay_len,
  input  logic                             reg_wr,
  input  logic [rr_pkg::reg_addr_bits-1:0] reg_addr,
  input  logic [31:0]                      reg_wdata,
  output logic [31:0]                      reg_rdata,
  output logic                             irq_req,
  input  logic                             irq_ack
);
  import rr_pkg::*;

  logic [mem_addr_bits:0]   buf_size;
  logic [31:0]              record_bits;
  logic [31:0]              replay_bits;
  logic                     record_finish, replay_start, write_done, read_done;
  logic                     mem_we, mem_re;
  logic [mem_addr_bits-1:0] mem_waddr, mem_raddr;
  logic [word_bits-1:0]     mem_wdata, mem_rdata;

  rr_backend_csr csr_inst (
    .clk           (clk),
    .rstn          (rstn),
    .reg_wr        (reg_wr),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .buf_size      (buf_size),
    .record_finish (record_finish),
    .replay_bits   (replay_bits),
    .replay_start  (replay_start),
    .record_bits   (record_bits),
    .write_done    (write_done),
    .read_done     (read_done),
    .irq_req       (irq_req),
    .irq_ack       (irq_ack)
  );

  rr_record_packer packer_inst (
    .clk           (clk),
    .rstn          (rstn),
    .record_valid  (record_valid),
    .record_ready  (record_ready),
    .record_data   (record_data),
    .record_len    (record_len),
    .buf_size      (buf_size),
    .record_finish (record_finish),
    .record_bits   (record_bits),
    .write_done    (write_done),
    .mem_we        (mem_we),
    .mem_waddr     (mem_waddr),
    .mem_wdata     (mem_wdata)
  );

  rr_replay_unpacker unpacker_inst (
    .clk          (clk),
    .rstn         (rstn),
    .replay_start (replay_start),
    .replay_bits  (replay_bits),
    .replay_valid (replay_valid),
    .replay_ready (replay_ready),
    .replay_data  (replay_data),
    .replay_len   (replay_len),
    .read_done    (read_done),
    .mem_re       (mem_re),
    .mem_raddr    (mem_raddr),
    .mem_rdata    (mem_rdata)
  );

  rr_trace_mem mem_inst (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .re    (mem_re),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

endmodule

//--- src/rr_backend_csr.sv
`timescale 1ns/1ps

module rr_backend_csr (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             reg_wr,
  input  logic [rr_pkg::reg_addr_bits-1:0] reg_addr,
  input  logic [31:0]                      reg_wdata,
  output logic [31:0]                      reg_rdata,
  output logic [rr_pkg::mem_addr_bits:0]   buf_size,
  output logic                             record_finish,
  output logic [31:0]                      replay_bits,
  output logic                             replay_start,
  input  logic [31:0]                      record_bits,
  input  logic                             write_done,
  input  logic                             read_done,
  output logic                             irq_req,
  input  logic                             irq_ack
);
  import rr_pkg::*;

  logic [1:0] irq_status;
  logic [1:0] irq_events;
  logic wr_ctrl, wr_buf_size, wr_replay_bits, wr_irq_status;

  assign wr_ctrl        = reg_wr && (reg_addr == reg_ctrl);
  assign wr_buf_size    = reg_wr && (reg_addr == reg_buf_size);
  assign wr_replay_bits = reg_wr && (reg_addr == reg_replay_bits);
  assign wr_irq_status  = reg_wr && (reg_addr == reg_irq_status);

  // Bit 0 is the write side, bit 1 the read side
  assign irq_events = {read_done, write_done};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      buf_size      <= (mem_addr_bits + 1)'(mem_depth);
      replay_bits   <= '0;
      record_finish <= 1'b0;
      replay_start  <= 1'b0;
      irq_status    <= '0;
      irq_req       <= 1'b0;
    end else begin
      record_finish <= wr_ctrl && reg_wdata[0];
      replay_start  <= wr_ctrl && reg_wdata[1];
      if (wr_buf_size) begin
        buf_size <= reg_wdata[mem_addr_bits:0];
      end
      if (wr_replay_bits) begin
        replay_bits <= reg_wdata;
      end
      // An event on the same edge as the clearing write is kept
      if (wr_irq_status) begin
        irq_status <= irq_events;
      end else begin
        irq_status <= irq_status | irq_events;
      end
      if (|irq_events) begin
        irq_req <= 1'b1;
      end else if (irq_ack) begin
        irq_req <= 1'b0;
      end
    end
  end

  // The control register holds only strobes and reads back as zero
  always_comb begin
    case (reg_addr)
      reg_buf_size:    reg_rdata = 32'(buf_size);
      reg_record_bits: reg_rdata = record_bits;
      reg_replay_bits: reg_rdata = replay_bits;
      reg_irq_status:  reg_rdata = 32'(irq_status);
      default:         reg_rdata = '0;
    endcase
  end

endmodule

//--- src/rr_replay_unpacker.sv
`timescale 1ns/1ps

module rr_replay_unpacker (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             replay_start,
  input  logic [31:0]                      replay_bits,
  output logic                             replay_valid,
  input  logic                             replay_ready,
  output logic [rr_pkg::max_unit_bits-1:0] replay_data,
  output logic [rr_pkg::unit_len_bits-1:0] replay_len,
  output logic                             read_done,
  output logic                             mem_re,
  output logic [rr_pkg::mem_addr_bits-1:0] mem_raddr,
  input  logic [rr_pkg::word_bits-1:0]     mem_rdata
);
  import rr_pkg::*;

  logic [word_bits+max_unit_bits-1:0] buf_q, popped, buf_d;
  logic [unit_len_bits:0]             fill_q, fill_pop, fill_d;
  logic [31:0]                        rd_cnt_q, out_cnt_q, words_needed;
  logic [unit_len_bits-1:0]           len;
  logic [max_unit_bits-1:0]           len_mask;
  logic active_q, pend_q, accept;

  // Number of words that hold the whole recorded stream
  assign words_needed = 32'((33'(replay_bits) + 33'd31) >> 5);

  // The unit at the bottom of the buffer is decoded from its bitmap
  assign len = unit_len(buf_q[chan_cnt-1:0]);
  assign len_mask = {max_unit_bits{1'b1}} >> (max_unit_bits - len);

  assign replay_len = len;
  assign replay_data = buf_q[max_unit_bits-1:0] & len_mask;
  assign replay_valid = active_q && (fill_q >= chan_cnt) && (fill_q >= len) &&
                        (out_cnt_q < replay_bits);
  assign accept = replay_valid && replay_ready;

  // A read still in flight counts as a full word already in the buffer
  assign mem_re = active_q && (rd_cnt_q < words_needed) &&
                  ((32'(fill_q) + (pend_q ? 32'(word_bits) : 32'd0)) < max_unit_bits);
  assign mem_raddr = rd_cnt_q[mem_addr_bits-1:0];

  always_comb begin
    popped = buf_q;
    fill_pop = fill_q;
    if (accept) begin
      popped = buf_q >> len;
      fill_pop = fill_q - (unit_len_bits + 1)'(len);
    end

    // Returning word lands above whatever is left after the pop
    buf_d = popped;
    fill_d = fill_pop;
    if (pend_q) begin
      buf_d = popped | ({{max_unit_bits{1'b0}}, mem_rdata} << fill_pop);
      fill_d = fill_pop + (unit_len_bits + 1)'(word_bits);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      buf_q     <= '0;
      fill_q    <= '0;
      rd_cnt_q  <= '0;
      out_cnt_q <= '0;
      pend_q    <= 1'b0;
      active_q  <= 1'b0;
      read_done <= 1'b0;
    end else if (replay_start) begin
      // Restart from word 0 and drop any read still in flight
      buf_q     <= '0;
      fill_q    <= '0;
      rd_cnt_q  <= '0;
      out_cnt_q <= '0;
      pend_q    <= 1'b0;
      active_q  <= 1'b1;
      read_done <= 1'b0;
    end else begin
      buf_q     <= buf_d;
      fill_q    <= fill_d;
      pend_q    <= mem_re;
      read_done <= 1'b0;
      if (mem_re) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
      end
      if (accept) begin
        out_cnt_q <= out_cnt_q + 32'(len);
        if ((out_cnt_q + 32'(len)) >= replay_bits) begin
          read_done <= 1'b1;
        end
      end
    end
  end

endmodule

//--- src/rr_record_packer.sv
`timescale 1ns/1ps

module rr_record_packer (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             record_valid,
  output logic                             record_ready,
  input  logic [rr_pkg::max_unit_bits-1:0] record_data,
  input  logic [rr_pkg::unit_len_bits-1:0] record_len,
  input  logic [rr_pkg::mem_addr_bits:0]   buf_size,
  input  logic                             record_finish,
  output logic [31:0]                      record_bits,
  output logic                             write_done,
  output logic                             mem_we,
  output logic [rr_pkg::mem_addr_bits-1:0] mem_waddr,
  output logic [rr_pkg::word_bits-1:0]     mem_wdata
);
  import rr_pkg::*;

  logic [word_bits+max_unit_bits-1:0] res_q, res_merged, res_d;
  logic [unit_len_bits:0]             fill_q, fill_merged, fill_d;
  logic [mem_addr_bits:0]             wcount_q;
  logic [max_unit_bits-1:0]           unit_mask;
  logic [word_bits-1:0]               wr_word;
  logic [31:0]                        cap_bits;
  logic active_q, flush_q, pad_q, done_q;
  logic accept, fits, flush_now, do_write, done_set;

  // Capacity of the buffer in bits
  assign cap_bits = 32'(buf_size) << 5;
  assign fits = (record_bits + 32'(record_len)) <= cap_bits;

  assign record_ready = active_q && !flush_q && !pad_q && !done_q && (fill_q < word_bits) && fits;
  assign accept = record_valid && record_ready;
  assign flush_now = flush_q || record_finish;
  assign unit_mask = {max_unit_bits{1'b1}} >> (max_unit_bits - record_len);

  always_comb begin
    res_merged = res_q;
    fill_merged = fill_q;
    if (accept) begin
      // New unit goes right above the bits already held
      res_merged = res_q | ({{word_bits{1'b0}}, record_data & unit_mask} << fill_q);
      fill_merged = fill_q + (unit_len_bits + 1)'(record_len);
    end
    wr_word = res_merged[word_bits-1:0];

    // Full words go out first, a flush pads the tail and a full buffer pads to the end
    do_write = 1'b0;
    if ((wcount_q < buf_size) && !done_q) begin
      if ((fill_merged >= word_bits) ||
          ((flush_now || pad_q) && ((fill_merged != 0) || pad_q))) begin
        do_write = 1'b1;
      end
    end

    res_d = res_merged;
    fill_d = fill_merged;
    if (do_write) begin
      res_d = res_merged >> word_bits;
      if (fill_merged > word_bits) begin
        fill_d = fill_merged - (unit_len_bits + 1)'(word_bits);
      end else begin
        fill_d = '0;
      end
    end

    done_set = active_q && !done_q &&
               ((wcount_q == buf_size) || (flush_now && (fill_merged == 0)));
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      res_q       <= '0;
      fill_q      <= '0;
      wcount_q    <= '0;
      active_q    <= 1'b0;
      flush_q     <= 1'b0;
      pad_q       <= 1'b0;
      done_q      <= 1'b0;
      record_bits <= '0;
      write_done  <= 1'b0;
      mem_we      <= 1'b0;
    end else begin
      active_q   <= 1'b1;
      res_q      <= res_d;
      fill_q     <= fill_d;
      mem_we     <= do_write;
      write_done <= done_set;
      if (do_write) begin
        wcount_q <= wcount_q + 1'b1;
      end
      if (accept) begin
        record_bits <= record_bits + 32'(record_len);
      end
      if (record_finish) begin
        flush_q <= 1'b1;
      end
      // A waiting unit that no longer fits closes the buffer
      if (active_q && record_valid && !fits && !flush_q && !done_q) begin
        pad_q <= 1'b1;
      end
      if (done_set) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem_waddr <= wcount_q[mem_addr_bits-1:0];
      mem_wdata <= wr_word;
    end
  end

endmodule

//--- src/rr_trace_mem.sv
`timescale 1ns/1ps

module rr_trace_mem (
  input  logic                             clk,
  input  logic                             we,
  input  logic [rr_pkg::mem_addr_bits-1:0] waddr,
  input  logic [rr_pkg::word_bits-1:0]     wdata,
  input  logic                             re,
  input  logic [rr_pkg::mem_addr_bits-1:0] raddr,
  output logic [rr_pkg::word_bits-1:0]     rdata
);
  import rr_pkg::*;

  logic [word_bits-1:0] mem [mem_depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // The read port is registered and data shows up one cycle after re
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

//--- src/rr_pkg.sv
package rr_pkg;

  // A log unit carries its bitmap first and then the payloads of the valid channels
  localparam int chan_cnt = 4;
  localparam int unit_len_bits = 7;

  // Channel 0 sits right above the bitmap
  localparam logic [chan_cnt-1:0][unit_len_bits-1:0] chan_widths = {
    7'd32, 7'd8, 7'd16, 7'd8
  };

  // Bitmap plus every payload
  localparam int max_unit_bits = 68;

  // Trace memory geometry
  localparam int word_bits = 32;
  localparam int mem_depth = 64;
  localparam int mem_addr_bits = 6;

  // Register map
  localparam int reg_addr_bits = 3;
  localparam logic [reg_addr_bits-1:0] reg_ctrl = 3'd0;
  localparam logic [reg_addr_bits-1:0] reg_buf_size = 3'd1;
  localparam logic [reg_addr_bits-1:0] reg_record_bits = 3'd2;
  localparam logic [reg_addr_bits-1:0] reg_replay_bits = 3'd3;
  localparam logic [reg_addr_bits-1:0] reg_irq_status = 3'd4;

  // Length of a unit in bits as given by its valid bitmap
  function automatic logic [unit_len_bits-1:0] unit_len(input logic [chan_cnt-1:0] bitmap);
    logic [unit_len_bits-1:0] len;
    len = unit_len_bits'(chan_cnt);
    for (int i = 0; i < chan_cnt; i++) begin
      if (bitmap[i]) begin
        len = len + chan_widths[i];
      end
    end
    return len;
  endfunction

endpackage
